// File: files.f
src/recorder_pkg.sv
src/frame_timer.sv
src/channel_sequencer.sv
src/sample_ram.sv
src/readout_port.sv
src/recorder_top.sv
sim/recorder_tb.sv

// File: sim/recorder_tb.sv
/* directed testbench for recorder_top, stops at the first error
   a position and frame model is checked against the DUT on every cycle */
module recorder_tb;
    import recorder_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;   // about 40 frames of 64 cycles plus reads, with margin

    logic         ck = 1'b0;
    logic         rst_n;
    logic         run;
    channel_set_t samples;
    logic         rd_strobe;
    read_req_t    rd_req;
    frame_posn_t  frame_posn;
    frame_num_t   frame;
    logic         rd_valid;
    read_rsp_t    rd_rsp;

    sample_t      ch_val [8];              // per channel input values, ch0 first
    sample_t      rec [33][8];             // frame_wrap samples, one row per frame run
    read_req_t    req_q [$];
    sample_t      exp_q [$];
    logic [5:0]   model_posn;
    logic [4:0]   model_frame;
    int           wrap_first;              // first slot written by frame_wrap
    int           cycles = 0;

    assign samples = {ch_val[0], ch_val[1], ch_val[2], ch_val[3],
                      ch_val[4], ch_val[5], ch_val[6], ch_val[7]};

    recorder_top UUT (
        .ck         (ck),
        .rst_n      (rst_n),
        .run        (run),
        .samples    (samples),
        .rd_strobe  (rd_strobe),
        .rd_req     (rd_req),
        .frame_posn (frame_posn),
        .frame      (frame),
        .rd_valid   (rd_valid),
        .rd_rsp     (rd_rsp)
    );

    always #20 ck = ~ck;

    always @(posedge ck) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not complete", cycles);
            stop_on_failure();
        end
    end

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // one clock, inputs change 1 unit after the edge, counters follow run at the edge
    task automatic step();
        logic stepped;
        stepped = run;
        @(posedge ck);
        #1;
        if (stepped) begin
            if (model_posn == 6'd63)
                model_frame = model_frame + 1'b1;
            model_posn = model_posn + 1'b1;
        end
        check("frame_timer posn", model_posn, frame_posn);
        check("frame_timer frame", model_frame, frame);
    endtask

    task automatic run_to(input int f, input int p);
        run = 1'b1;
        while (!(model_frame == f && model_posn == p))
            step();
    endtask

    task automatic next_frame_start();
        run = 1'b1;
        while (model_posn != 0)
            step();
    endtask

    function automatic read_req_t make_req(input int f, input int k);
        read_req_t req;
        req.frame   = frame_num_t'(f);
        req.channel = channel_t'(k);
        return req;
    endfunction

    // channel k at position p gets a distinct word, so a wrong capture instant shows
    function automatic sample_t code_value(input sample_t base, input int p, input int k);
        return sample_t'(base + k * 256 + p);
    endfunction

    task automatic read_one(input string name, input read_req_t req, input sample_t data);
        int waited;
        rd_strobe = 1'b1;
        rd_req    = req;
        step();
        rd_strobe = 1'b0;
        waited    = 1;
        while (!rd_valid) begin
            if (waited >= 2) begin
                $display("%s: rd_valid did not arrive within 2 cycles of rd_strobe", name);
                stop_on_failure();
            end
            step();
            waited++;
        end
        check({name, " latency"}, 2, waited);
        check({name, " tag"}, req, rd_rsp.tag);
        check({name, " data"}, data, rd_rsp.data);
    endtask

    // issues every queued request on back-to-back cycles, each answered 2 cycles later
    task automatic read_burst(input string name);
        int n;
        int t;
        n = req_q.size();
        for (t = 0; t <= n; t++) begin
            if (t < n) begin
                rd_strobe = 1'b1;
                rd_req    = req_q[t];
            end else begin
                rd_strobe = 1'b0;
            end
            step();
            if (t == 0) begin
                check({name, " early valid"}, 0, rd_valid);
            end else begin
                check($sformatf("%s valid %0d", name, t - 1), 1, rd_valid);
                check($sformatf("%s tag %0d", name, t - 1), req_q[t-1], rd_rsp.tag);
                check($sformatf("%s data %0d", name, t - 1), exp_q[t-1], rd_rsp.data);
            end
        end
        step();
        check({name, " valid after burst"}, 0, rd_valid);
        req_q.delete();
        exp_q.delete();
    endtask

    task automatic verify_reset();
        check("reset posn", 0, frame_posn);
        check("reset frame", 0, frame);
        check("reset rd_valid", 0, rd_valid);
        repeat (5) step();   // counters must hold while run stays low
        check("reset rd_valid hold", 0, rd_valid);
    endtask

    task automatic capture_one_frame();
        int k;
        for (k = 0; k < 8; k++)
            ch_val[k] = sample_t'(16'h1000 + k * 16'h0111);
        run_to(1, 16);
        for (k = 0; k < 8; k++)
            read_one($sformatf("single_frame ch%0d", k), make_req(0, k),
                     sample_t'(16'h1000 + k * 16'h0111));
    endtask

    task automatic sampling_instant();
        int f;
        int k;
        next_frame_start();
        f = model_frame;
        while (model_posn < 16) begin
            for (k = 0; k < 8; k++)
                ch_val[k] = code_value(16'h3000, model_posn, k);
            step();
        end
        for (k = 0; k < 8; k++)
            read_one($sformatf("sampling_instant ch%0d", k), make_req(f, k),
                     code_value(16'h3000, 2 * k, k));
    endtask

    task automatic frame_wrap();
        int i;
        int k;
        int slot;
        int age;
        next_frame_start();
        wrap_first = model_frame;
        for (i = 0; i < 33; i++) begin
            for (k = 0; k < 8; k++) begin
                ch_val[k] = sample_t'($urandom);
                rec[i][k] = ch_val[k];
            end
            repeat (FRAME_LEN) step();
        end
        run = 1'b0;   // recorder parked at position 0, no writes during readback
        for (slot = 0; slot < 32; slot++) begin
            age = (slot - wrap_first + 32) % 32;
            if (age == 0)
                age = 32;   // the 33rd frame lands on the first slot again
            for (k = 0; k < 8; k++) begin
                req_q.push_back(make_req(slot, k));
                exp_q.push_back(rec[age][k]);
            end
        end
        read_burst("frame_wrap");
    endtask

    task automatic pause_and_resume();
        int f;
        int k;
        logic paused;
        next_frame_start();
        f      = model_frame;
        paused = 1'b0;
        while (model_posn < 16) begin
            if (model_posn == 8 && !paused) begin
                run = 1'b0;
                repeat (5) begin
                    for (k = 0; k < 8; k++)
                        ch_val[k] = sample_t'($urandom);
                    step();
                end
                check("pause posn held", 8, frame_posn);
                run    = 1'b1;
                paused = 1'b1;
            end
            for (k = 0; k < 8; k++)
                ch_val[k] = code_value(16'h5000, model_posn, k);
            step();
        end
        for (k = 0; k < 8; k++)
            read_one($sformatf("pause ch%0d", k), make_req(f, k),
                     code_value(16'h5000, 2 * k, k));
    endtask

    task automatic read_pipeline();
        int f;
        int k;
        int slot;
        f    = model_frame;   // the frame written by pause_and_resume
        slot = (wrap_first + 10) % 32;
        for (k = 7; k >= 0; k--) begin
            req_q.push_back(make_req(f, k));
            exp_q.push_back(code_value(16'h5000, 2 * k, k));
        end
        for (k = 0; k < 4; k++) begin
            req_q.push_back(make_req(slot, k));
            exp_q.push_back(rec[10][k]);
        end
        read_burst("read_pipeline");
    endtask

    initial begin
        void'($urandom(32'h2900_f8e5));
        rst_n       = 1'b0;
        run         = 1'b0;
        rd_strobe   = 1'b0;
        rd_req      = '0;
        model_posn  = '0;
        model_frame = '0;
        wrap_first  = 0;
        for (int k = 0; k < 8; k++)
            ch_val[k] = '0;
        repeat (3) @(posedge ck);
        #1;
        rst_n = 1'b1;
        verify_reset();
        capture_one_frame();
        sampling_instant();
        frame_wrap();
        pause_and_resume();
        read_pipeline();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: src/channel_sequencer.sv
/* captures channel k when frame_posn is 2k and pulses a RAM write on the next cycle
   all captures and state moves wait for advance, a write already launched still completes */
module channel_sequencer (
    input  logic                       ck,
    input  logic                       rst_n,
    input  logic                       advance,
    input  recorder_pkg::frame_posn_t  frame_posn,
    input  recorder_pkg::frame_num_t   frame,
    input  recorder_pkg::channel_set_t samples,
    output logic                       wr_strobe,
    output recorder_pkg::ram_write_t   wr
);
    import recorder_pkg::*;

    seq_state_t state;
    channel_t   channel;
    sample_t    selected;
    logic       at_last_posn;
    logic       last_channel;
    logic       capture;

    assign at_last_posn = (frame_posn == frame_posn_t'(LAST_POSN));
    assign last_channel = (channel == channel_t'(NUM_CHANNELS - 1));

    // pick the current channel out of the input set
    always_comb begin
        case (channel)
            3'd0:    selected = samples.ch0;
            3'd1:    selected = samples.ch1;
            3'd2:    selected = samples.ch2;
            3'd3:    selected = samples.ch3;
            3'd4:    selected = samples.ch4;
            3'd5:    selected = samples.ch5;
            3'd6:    selected = samples.ch6;
            default: selected = samples.ch7;
        endcase
    end

    // a capture starts a frame at position 0, or follows each write slot
    always_comb begin
        capture = 1'b0;
        if (advance && !at_last_posn) begin
            case (state)
                WAIT_FRAME: capture = (frame_posn == '0);
                GAP:        capture = 1'b1;
                default:    capture = 1'b0;
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            state     <= WAIT_FRAME;
            channel   <= '0;
            wr_strobe <= 1'b0;
        end else begin
            wr_strobe <= capture;   // exactly one cycle per captured sample
            if (advance) begin
                if (at_last_posn) begin
                    // the last position of a frame always sends the sequence back to wait
                    state   <= WAIT_FRAME;
                    channel <= '0;
                end else begin
                    case (state)
                        WAIT_FRAME: begin
                            if (capture)
                                state <= WRITE;
                        end
                        WRITE: begin
                            if (last_channel) begin
                                state   <= WAIT_FRAME;
                                channel <= '0;
                            end else begin
                                state   <= GAP;
                                channel <= channel + 1'b1;
                            end
                        end
                        GAP: begin
                            state <= WRITE;
                        end
                        default: begin
                            state   <= WAIT_FRAME;
                            channel <= '0;
                        end
                    endcase
                end
            end
        end
    end

    // sample and address are latched together so the pair stays consistent
    always_ff @(posedge ck) begin
        if (capture) begin
            wr.addr <= pack_addr(channel, frame);
            wr.data <= selected;
        end
    end

endmodule

// File: src/frame_timer.sv
/* position and frame counters, both hold while run is low
   advance marks each cycle on which the recorder steps */
module frame_timer (
    input  logic                     ck,
    input  logic                     rst_n,
    input  logic                     run,
    output recorder_pkg::frame_posn_t frame_posn,
    output recorder_pkg::frame_num_t  frame,
    output logic                     advance
);
    import recorder_pkg::*;

    // every timing block downstream steps on this qualified cycle
    assign advance = run;

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            frame_posn <= '0;
            frame      <= '0;
        end else if (advance) begin
            if (frame_posn == frame_posn_t'(LAST_POSN)) begin
                frame_posn <= '0;
                frame      <= frame + 1'b1;   // rolls from 31 back to 0 by width
            end else begin
                frame_posn <= frame_posn + 1'b1;
            end
        end
    end

endmodule

// File: src/readout_port.sv
/* frame/channel reads answered with rd_valid two cycles after rd_strobe
   reads may be issued every cycle, so two can be in flight, and there is no back-pressure */
module readout_port (
    input  logic                     ck,
    input  logic                     rst_n,
    input  logic                     rd_strobe,
    input  recorder_pkg::read_req_t  rd_req,
    output logic                     rd_en,
    output recorder_pkg::ram_addr_t  rd_addr,
    input  recorder_pkg::sample_t    rd_data,
    output logic                     rd_valid,
    output recorder_pkg::read_rsp_t  rd_rsp
);
    import recorder_pkg::*;

    read_req_t tag_q1;      // request tag alongside rd_en
    read_req_t tag_q2;      // request tag alongside rd_data
    logic      valid_q2;

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            rd_en    <= 1'b0;
            valid_q2 <= 1'b0;
        end else begin
            rd_en    <= rd_strobe;
            valid_q2 <= rd_en;
        end
    end

    // the tags follow the RAM latency stage for stage
    always_ff @(posedge ck) begin
        if (rd_strobe) begin
            rd_addr <= pack_addr(rd_req.channel, rd_req.frame);
            tag_q1  <= rd_req;
        end
        if (rd_en)
            tag_q2 <= tag_q1;
    end

    // both halves of the response already come from registers
    assign rd_valid    = valid_q2;
    assign rd_rsp.tag  = tag_q2;
    assign rd_rsp.data = rd_data;

endmodule

// File: src/recorder_pkg.sv
/* shared widths, types and constants of the signal recorder
   the RAM address packing fixes every size here, so nothing is parameterized per module */
package recorder_pkg;

    localparam int FRAME_LEN    = 64;   // positions per frame
    localparam int LAST_POSN    = FRAME_LEN - 1;
    localparam int NUM_CHANNELS = 8;

    typedef logic [15:0]                       sample_t;
    typedef logic [$clog2(FRAME_LEN)-1:0]      frame_posn_t;
    typedef logic [4:0]                        frame_num_t;   // wraps 0 to 31
    typedef logic [$clog2(NUM_CHANNELS)-1:0]   channel_t;
    typedef logic [7:0]                        ram_addr_t;

    // one sample per input channel, these are the recorder inputs
    typedef struct packed {
        sample_t ch0;
        sample_t ch1;
        sample_t ch2;
        sample_t ch3;
        sample_t ch4;
        sample_t ch5;
        sample_t ch6;
        sample_t ch7;
    } channel_set_t;

    typedef struct packed {
        ram_addr_t addr;
        sample_t   data;
    } ram_write_t;

    typedef struct packed {
        frame_num_t frame;
        channel_t   channel;
    } read_req_t;

    typedef struct packed {
        read_req_t tag;     // the request this word answers
        sample_t   data;
    } read_rsp_t;

    typedef enum logic [1:0] {WAIT_FRAME, WRITE, GAP} seq_state_t;

    // channel goes in the upper bits and frame in the lower bits of the word address
    function automatic ram_addr_t pack_addr(channel_t channel, frame_num_t frame);
        return {channel, frame};
    endfunction

endpackage

// File: src/recorder_top.sv
/* eight-channel recorder, channels 0 to 7 captured in the first 16 positions of each frame
   32 frames of history are kept and a slot is overwritten when its frame number comes round */
module recorder_top (
    input  logic                       ck,
    input  logic                       rst_n,
    input  logic                       run,
    input  recorder_pkg::channel_set_t samples,
    input  logic                       rd_strobe,
    input  recorder_pkg::read_req_t    rd_req,
    output recorder_pkg::frame_posn_t  frame_posn,
    output recorder_pkg::frame_num_t   frame,
    output logic                       rd_valid,
    output recorder_pkg::read_rsp_t    rd_rsp
);
    import recorder_pkg::*;

    logic       advance;
    logic       wr_strobe;
    ram_write_t wr;
    logic       rd_en;
    ram_addr_t  rd_addr;
    sample_t    rd_data;

    frame_timer u_frame_timer (
        .ck         (ck),
        .rst_n      (rst_n),
        .run        (run),
        .frame_posn (frame_posn),
        .frame      (frame),
        .advance    (advance)
    );

    channel_sequencer u_channel_sequencer (
        .ck         (ck),
        .rst_n      (rst_n),
        .advance    (advance),
        .frame_posn (frame_posn),
        .frame      (frame),
        .samples    (samples),
        .wr_strobe  (wr_strobe),
        .wr         (wr)
    );

    sample_ram u_sample_ram (
        .ck         (ck),
        .wr_strobe  (wr_strobe),
        .wr         (wr),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    // reads are independent of run and may target any frame slot
    readout_port u_readout_port (
        .ck         (ck),
        .rst_n      (rst_n),
        .rd_strobe  (rd_strobe),
        .rd_req     (rd_req),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .rd_rsp     (rd_rsp)
    );

endmodule

// File: src/sample_ram.sv
/* 256 x 16 dual-port RAM with one write and one registered read port
   contents are not reset, and a read of the address being written returns the old word */
module sample_ram (
    input  logic                     ck,
    input  logic                     wr_strobe,
    input  recorder_pkg::ram_write_t wr,
    input  logic                     rd_en,
    input  recorder_pkg::ram_addr_t  rd_addr,
    output recorder_pkg::sample_t    rd_data
);
    import recorder_pkg::*;

    sample_t mem [2**$bits(ram_addr_t)];

    always_ff @(posedge ck) begin
        if (wr_strobe)
            mem[wr.addr] <= wr.data;
    end

    // data follows rd_en by one cycle and holds until the next read
    always_ff @(posedge ck) begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule
